// File: src.f
source/ipod_pkg.sv
source/flash_pkg.sv
source/key_sync.sv
source/rate_control.sv
source/kbd_command.sv
source/address_gen.sv
source/flash_reader.sv
source/ipod_top.sv
bench/ipod_chk.sv
bench/flash_model.sv
bench/ipod_tb.sv

// File: bench/ipod_tb.sv
`default_nettype none

module ipod_tb;

  timeunit 1ns;
  timeprecision 1ps;

  logic                  CLK_50M;
  logic                  rst_n;
  ipod_pkg::speed_keys_t keys_n;
  ipod_pkg::ascii_t      ascii;
  logic                  ascii_valid;
  flash_pkg::flash_req_t flash_req;
  flash_pkg::flash_rsp_t flash_rsp;
  ipod_pkg::sample_t     sample;
  logic                  sample_valid;
  ipod_pkg::divisor_t    rate_divisor;

  // Expected play position and speed
  flash_pkg::word_addr_t exp_addr;
  logic                  exp_half;
  logic                  exp_forward;
  ipod_pkg::divisor_t    exp_divisor;

  localparam int sample_timeout = 2 * ipod_pkg::max_divisor + 100;

  ipod_top u_ipod_top (
    .CLK_50M      (CLK_50M),
    .rst_n        (rst_n),
    .keys_n       (keys_n),
    .ascii        (ascii),
    .ascii_valid  (ascii_valid),
    .flash_req    (flash_req),
    .flash_rsp    (flash_rsp),
    .sample       (sample),
    .sample_valid (sample_valid),
    .rate_divisor (rate_divisor)
  );

  flash_model u_flash_model (
    .CLK_50M   (CLK_50M),
    .rst_n     (rst_n),
    .flash_req (flash_req),
    .flash_rsp (flash_rsp)
  );

  initial
    CLK_50M = 1'b0;

  always #10 CLK_50M = ~CLK_50M;

  // ==============================
  // Helpers
  // ==============================

  task automatic stop_with_failure(input string what);
    begin
      $display("%s", what);
      $display("TEST FAILED");
      $fatal(1, "simulation stopped at first error");
    end
  endtask

  task automatic check_sample(input string name, input ipod_pkg::sample_t got,
                              input ipod_pkg::sample_t exp);
    begin
      if (got !== exp)
        stop_with_failure($sformatf("error at %0t: %s is %h, expected %h",
                                    $time, name, got, exp));
    end
  endtask

  task automatic check_divisor(input string name, input ipod_pkg::divisor_t got,
                               input ipod_pkg::divisor_t exp);
    begin
      if (got !== exp)
        stop_with_failure($sformatf("error at %0t: %s is %0d, expected %0d",
                                    $time, name, got, exp));
    end
  endtask

  task automatic check_address(input string name, input flash_pkg::word_addr_t got,
                               input flash_pkg::word_addr_t exp);
    begin
      if (got !== exp)
        stop_with_failure($sformatf("error at %0t: %s is %h, expected %h",
                                    $time, name, got, exp));
    end
  endtask

  // Flash word at address a is {~a[15:0], a[15:0]}
  function automatic ipod_pkg::sample_t expected_sample(flash_pkg::word_addr_t a, logic h);
    if (h)
      return ~a[15:0];
    else
      return a[15:0];
  endfunction

  task automatic step_position();
    begin
      if (exp_forward && exp_half)
        exp_addr = (exp_addr == flash_pkg::last_word_addr) ? '0 : exp_addr + 1'b1;
      else if (!exp_forward && !exp_half)
        exp_addr = (exp_addr == '0) ? flash_pkg::last_word_addr : exp_addr - 1'b1;
      exp_half = ~exp_half;
    end
  endtask

  task automatic wait_sample(output flash_pkg::word_addr_t read_addr);
    int cycles;
    begin
      cycles    = 0;
      read_addr = 'x;
      @(negedge CLK_50M);
      while (!sample_valid)
      begin
        // Address of the read behind this sample
        if (flash_req.read)
          read_addr = flash_req.address;
        cycles++;
        if (cycles > sample_timeout)
          stop_with_failure("timeout while waiting for sample_valid");
        @(negedge CLK_50M);
      end
    end
  endtask

  task automatic expect_samples(input int count);
    flash_pkg::word_addr_t read_addr;
    begin
      repeat (count)
      begin
        wait_sample(read_addr);
        check_address("flash_req.address", read_addr, exp_addr);
        check_sample("sample", sample, expected_sample(exp_addr, exp_half));
        step_position();
      end
    end
  endtask

  task automatic send_cmd(input ipod_pkg::ascii_t code);
    begin
      ascii       = code;
      ascii_valid = 1'b1;
      @(negedge CLK_50M);
      ascii_valid = 1'b0;
      ascii       = '0;
    end
  endtask

  // Key is held past the three-cycle sync delay and then released
  task automatic press_key(input logic up, input logic down, input logic rst);
    begin
      keys_n.up    = ~up;
      keys_n.down  = ~down;
      keys_n.reset = ~rst;
      repeat (6) @(negedge CLK_50M);
      keys_n = '1;
      repeat (6) @(negedge CLK_50M);
    end
  endtask

  task automatic stay_quiet(input int cycles);
    begin
      repeat (cycles)
      begin
        @(negedge CLK_50M);
        if (sample_valid || flash_req.read)
          stop_with_failure("read or sample appeared while the player was paused");
      end
    end
  endtask

  always @(negedge CLK_50M)
  begin
    if (u_ipod_top.u_chk.fail_count != 0)
      stop_with_failure("an assertion on the DUT failed");
  end

  // ==============================
  // Directed tests
  // ==============================

  task automatic after_reset_idle();
    begin
      check_divisor("rate_divisor", rate_divisor, ipod_pkg::default_divisor);
      stay_quiet(3 * ipod_pkg::default_divisor);
    end
  endtask

  task automatic forward_play();
    begin
      send_cmd(ipod_pkg::cmd_play);
      expect_samples(8);
      send_cmd(ipod_pkg::cmd_pause);
    end
  endtask

  task automatic speed_keys();
    begin
      repeat (11)
      begin
        press_key(1'b1, 1'b0, 1'b0);
        if (exp_divisor - ipod_pkg::speed_step >= ipod_pkg::min_divisor)
          exp_divisor = exp_divisor - ipod_pkg::speed_step;
        check_divisor("rate_divisor", rate_divisor, exp_divisor);
      end
      repeat (21)
      begin
        press_key(1'b0, 1'b1, 1'b0);
        if (exp_divisor + ipod_pkg::speed_step <= ipod_pkg::max_divisor)
          exp_divisor = exp_divisor + ipod_pkg::speed_step;
        check_divisor("rate_divisor", rate_divisor, exp_divisor);
      end
      press_key(1'b0, 1'b0, 1'b1);
      exp_divisor = ipod_pkg::default_divisor;
      check_divisor("rate_divisor", rate_divisor, exp_divisor);
    end
  endtask

  task automatic backward_and_wrap();
    begin
      send_cmd(ipod_pkg::cmd_backward);
      exp_forward = 1'b0;
      send_cmd(ipod_pkg::cmd_restart);
      exp_addr = flash_pkg::last_word_addr;
      exp_half = 1'b1;
      send_cmd(ipod_pkg::cmd_play);
      expect_samples(3);
      send_cmd(ipod_pkg::cmd_forward);
      exp_forward = 1'b1;
      send_cmd(ipod_pkg::cmd_restart);
      exp_addr = '0;
      exp_half = 1'b0;
      expect_samples(2);
      // Back across word 0 into the top of the area
      send_cmd(ipod_pkg::cmd_backward);
      exp_forward = 1'b0;
      expect_samples(4);
    end
  endtask

  task automatic pause_and_resume();
    begin
      send_cmd(ipod_pkg::cmd_pause);
      stay_quiet(3 * rate_divisor);
      send_cmd(ipod_pkg::cmd_play);
      expect_samples(2);
    end
  endtask

  initial
  begin
    rst_n       = 1'b0;
    keys_n      = '1;
    ascii       = '0;
    ascii_valid = 1'b0;
    exp_addr    = '0;
    exp_half    = 1'b0;
    exp_forward = 1'b1;
    exp_divisor = ipod_pkg::default_divisor;
    repeat (16) @(negedge CLK_50M);
    rst_n = 1'b1;

    after_reset_idle();
    forward_play();
    speed_keys();
    backward_and_wrap();
    pause_and_resume();

    if (u_ipod_top.u_chk.fail_count != 0)
      stop_with_failure("an assertion on the DUT failed");
    else
    begin
      $display("TEST OK");
      $finish;
    end
  end

endmodule

`default_nettype wire

// File: bench/flash_model.sv
`default_nettype none

module flash_model (
  input  wire                        CLK_50M,
  input  wire                        rst_n,
  input  wire flash_pkg::flash_req_t flash_req,
  output flash_pkg::flash_rsp_t      flash_rsp
);

  timeunit 1ns;
  timeprecision 1ps;

  integer                seed       = 32'hc958c834;
  logic [1:0]            wait_left  = 2'd0;
  logic [2:0]            data_left  = 3'd0;
  logic                  pending    = 1'b0;
  logic                  valid_q    = 1'b0;
  flash_pkg::word_t      data_q     = '0;
  flash_pkg::word_addr_t taken_addr = '0;

  always @(posedge CLK_50M)
  begin
    if (!rst_n)
    begin
      pending   <= 1'b0;
      valid_q   <= 1'b0;
      wait_left <= 2'($random(seed) & 3);
    end
    else
    begin
      valid_q <= 1'b0;
      if (flash_req.read && !pending)
      begin
        if (wait_left != 2'd0)
          wait_left <= wait_left - 2'd1;
        else
        begin
          // Accepted, data comes 1 to 4 cycles later
          pending    <= 1'b1;
          taken_addr <= flash_req.address;
          data_left  <= 3'(($random(seed) & 3) + 1);
        end
      end
      else if (pending)
      begin
        if (data_left == 3'd1)
        begin
          valid_q   <= 1'b1;
          data_q    <= {~taken_addr[15:0], taken_addr[15:0]};
          pending   <= 1'b0;
          // Stall length for the next request
          wait_left <= 2'($random(seed) & 3);
        end
        else
          data_left <= data_left - 3'd1;
      end
    end
  end

  always_comb
  begin
    flash_rsp.waitrequest   = flash_req.read && (pending || wait_left != 2'd0);
    flash_rsp.readdatavalid = valid_q;
    flash_rsp.readdata      = data_q;
  end

endmodule

`default_nettype wire

// File: bench/ipod_chk.sv
`default_nettype none

module ipod_chk (
  input wire                        CLK_50M,
  input wire                        rst_n,
  input wire flash_pkg::flash_req_t flash_req,
  input wire flash_pkg::flash_rsp_t flash_rsp,
  input wire                        sample_valid,
  input wire ipod_pkg::divisor_t    rate_divisor
);

  timeunit 1ns;
  timeprecision 1ps;

  // Number of assertion failures so far
  int unsigned fail_count = 0;

  // Stalled request must hold still
  req_held: assert property (@(posedge CLK_50M) disable iff (!rst_n)
    flash_req.read && flash_rsp.waitrequest |=> flash_req.read && $stable(flash_req.address))
  else
  begin
    fail_count++;
    $error("read or address changed while waitrequest was high");
  end

  valid_single: assert property (@(posedge CLK_50M) disable iff (!rst_n)
    sample_valid |=> !sample_valid)
  else
  begin
    fail_count++;
    $error("sample_valid lasted two cycles");
  end

  divisor_range: assert property (@(posedge CLK_50M) disable iff (!rst_n)
    rate_divisor >= ipod_pkg::min_divisor && rate_divisor <= ipod_pkg::max_divisor)
  else
  begin
    fail_count++;
    $error("rate_divisor out of range");
  end

  // Reset edge puts the reader in idle
  read_in_reset: assert property (@(posedge CLK_50M) !rst_n |=> !flash_req.read)
  else
  begin
    fail_count++;
    $error("read high during reset");
  end

endmodule

bind ipod_top ipod_chk u_chk (
  .CLK_50M      (CLK_50M),
  .rst_n        (rst_n),
  .flash_req    (flash_req),
  .flash_rsp    (flash_rsp),
  .sample_valid (sample_valid),
  .rate_divisor (rate_divisor)
);

`default_nettype wire

// File: source/ipod_top.sv
`default_nettype none

module ipod_top (
  input  wire                        CLK_50M,
  input  wire                        rst_n,
  input  wire ipod_pkg::speed_keys_t keys_n,
  input  wire ipod_pkg::ascii_t      ascii,
  input  wire                        ascii_valid,
  output flash_pkg::flash_req_t      flash_req,
  input  wire flash_pkg::flash_rsp_t flash_rsp,
  output ipod_pkg::sample_t          sample,
  output logic                       sample_valid,
  output ipod_pkg::divisor_t         rate_divisor
);

  ipod_pkg::speed_keys_t key_events;
  ipod_pkg::play_ctrl_t  ctrl;
  flash_pkg::word_addr_t word_addr;
  logic                  half;
  logic                  sample_tick;
  logic                  advance;

  // ==============================
  // Speed control
  // ==============================

  key_sync u_key_sync (
    .CLK_50M (CLK_50M),
    .rst_n   (rst_n),
    .keys_n  (keys_n),
    .events  (key_events)
  );

  rate_control u_rate_control (
    .CLK_50M      (CLK_50M),
    .rst_n        (rst_n),
    .events       (key_events),
    .rate_divisor (rate_divisor),
    .sample_tick  (sample_tick)
  );

  // ==============================
  // Playback
  // ==============================

  kbd_command u_kbd_command (
    .CLK_50M     (CLK_50M),
    .rst_n       (rst_n),
    .ascii       (ascii),
    .ascii_valid (ascii_valid),
    .ctrl        (ctrl)
  );

  address_gen u_address_gen (
    .CLK_50M   (CLK_50M),
    .rst_n     (rst_n),
    .ctrl      (ctrl),
    .advance   (advance),
    .word_addr (word_addr),
    .half      (half)
  );

  flash_reader u_flash_reader (
    .CLK_50M      (CLK_50M),
    .rst_n        (rst_n),
    .sample_tick  (sample_tick),
    .playing      (ctrl.playing),
    .word_addr    (word_addr),
    .half         (half),
    .flash_req    (flash_req),
    .flash_rsp    (flash_rsp),
    .sample       (sample),
    .sample_valid (sample_valid),
    .advance      (advance)
  );

endmodule

`default_nettype wire

// File: source/flash_reader.sv
`default_nettype none

module flash_reader (
  input  wire                        CLK_50M,
  input  wire                        rst_n,
  input  wire                        sample_tick,
  input  wire                        playing,
  input  wire flash_pkg::word_addr_t word_addr,
  input  wire                        half,
  output flash_pkg::flash_req_t      flash_req,
  input  wire flash_pkg::flash_rsp_t flash_rsp,
  output ipod_pkg::sample_t          sample,
  output logic                       sample_valid,
  output logic                       advance
);

  typedef enum logic [1:0] {
    st_idle,
    st_request,
    st_wait_data
  } state_t;

  state_t                state;
  flash_pkg::word_addr_t req_addr;
  logic                  req_half;

  // ==============================
  // Read FSM
  // ==============================

  always_ff @(posedge CLK_50M)
  begin
    if (!rst_n)
    begin
      state        <= st_idle;
      sample_valid <= 1'b0;
      advance      <= 1'b0;
    end
    else
    begin
      sample_valid <= 1'b0;
      advance      <= 1'b0;
      case (state)
        st_idle:
        begin
          // Skip the advance cycle, the position is still the old one
          if (sample_tick && playing && !advance)
            state <= st_request;
        end
        st_request:
        begin
          // Held until the slave drops waitrequest
          if (!flash_rsp.waitrequest)
            state <= st_wait_data;
        end
        st_wait_data:
        begin
          if (flash_rsp.readdatavalid)
          begin
            sample_valid <= 1'b1;
            advance      <= 1'b1;
            state        <= st_idle;
          end
        end
        default:
        begin
          state <= st_idle;
        end
      endcase
    end
  end

  // Address and half frozen for the whole read
  always_ff @(posedge CLK_50M)
  begin
    if (state == st_idle)
    begin
      req_addr <= word_addr;
      req_half <= half;
    end
  end

  // Pick the half-word when the data shows up
  always_ff @(posedge CLK_50M)
  begin
    if (state == st_wait_data && flash_rsp.readdatavalid)
    begin
      if (req_half)
        sample <= flash_rsp.readdata[31:16];
      else
        sample <= flash_rsp.readdata[15:0];
    end
  end

  always_comb
  begin
    flash_req.read    = (state == st_request);
    flash_req.address = req_addr;
  end

endmodule

`default_nettype wire

// File: source/address_gen.sv
`default_nettype none

module address_gen (
  input  wire                       CLK_50M,
  input  wire                       rst_n,
  input  wire ipod_pkg::play_ctrl_t ctrl,
  input  wire                       advance,
  output flash_pkg::word_addr_t     word_addr,
  output logic                      half
);

  // Position is word_addr plus half, half 0 is the low 16 bits
  always_ff @(posedge CLK_50M)
  begin
    if (!rst_n)
    begin
      word_addr <= '0;
      half      <= 1'b0;
    end
    else if (ctrl.restart)
    begin
      // Jump to the start of the play direction
      if (ctrl.forward)
      begin
        word_addr <= '0;
        half      <= 1'b0;
      end
      else
      begin
        word_addr <= flash_pkg::last_word_addr;
        half      <= 1'b1;
      end
    end
    else if (advance)
    begin
      half <= ~half;
      // Word only moves when the half wraps
      if (ctrl.forward && half)
      begin
        if (word_addr == flash_pkg::last_word_addr)
          word_addr <= '0;
        else
          word_addr <= word_addr + 1'b1;
      end
      else if (!ctrl.forward && !half)
      begin
        if (word_addr == '0)
          word_addr <= flash_pkg::last_word_addr;
        else
          word_addr <= word_addr - 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: source/kbd_command.sv
`default_nettype none

module kbd_command (
  input  wire                   CLK_50M,
  input  wire                   rst_n,
  input  wire ipod_pkg::ascii_t ascii,
  input  wire                   ascii_valid,
  output ipod_pkg::play_ctrl_t  ctrl
);

  always_ff @(posedge CLK_50M)
  begin
    if (!rst_n)
    begin
      // Paused and forward
      ctrl.playing <= 1'b0;
      ctrl.forward <= 1'b1;
      ctrl.restart <= 1'b0;
    end
    else
    begin
      // Restart only lasts one cycle
      ctrl.restart <= 1'b0;
      if (ascii_valid)
      begin
        case (ascii)
          ipod_pkg::cmd_play:     ctrl.playing <= 1'b1;
          ipod_pkg::cmd_pause:    ctrl.playing <= 1'b0;
          ipod_pkg::cmd_forward:  ctrl.forward <= 1'b1;
          ipod_pkg::cmd_backward: ctrl.forward <= 1'b0;
          ipod_pkg::cmd_restart:  ctrl.restart <= 1'b1;
          // Other keys do nothing
          default: ;
        endcase
      end
    end
  end

endmodule

`default_nettype wire

// File: source/rate_control.sv
`default_nettype none

module rate_control (
  input  wire                        CLK_50M,
  input  wire                        rst_n,
  input  wire ipod_pkg::speed_keys_t events,
  output ipod_pkg::divisor_t         rate_divisor,
  output logic                       sample_tick
);

  ipod_pkg::divisor_t tick_count;

  // ==============================
  // Speed register
  // ==============================

  always_ff @(posedge CLK_50M)
  begin
    if (!rst_n)
      rate_divisor <= ipod_pkg::default_divisor;
    else if (events.reset)
      rate_divisor <= ipod_pkg::default_divisor;
    else if (events.up)
    begin
      // Faster means a smaller divisor
      if (rate_divisor >= ipod_pkg::min_divisor + ipod_pkg::speed_step)
        rate_divisor <= rate_divisor - ipod_pkg::speed_step;
    end
    else if (events.down)
    begin
      if (rate_divisor <= ipod_pkg::max_divisor - ipod_pkg::speed_step)
        rate_divisor <= rate_divisor + ipod_pkg::speed_step;
    end
  end

  // ==============================
  // Sample tick counter
  // ==============================

  // Counts rate_divisor-1 down to 0, so one tick every rate_divisor cycles
  always_ff @(posedge CLK_50M)
  begin
    if (!rst_n)
    begin
      tick_count  <= ipod_pkg::default_divisor - 16'd1;
      sample_tick <= 1'b0;
    end
    else if (tick_count == '0)
    begin
      // Divisor changes are picked up here
      tick_count  <= rate_divisor - 16'd1;
      sample_tick <= 1'b1;
    end
    else
    begin
      tick_count  <= tick_count - 16'd1;
      sample_tick <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// File: source/key_sync.sv
`default_nettype none

module key_sync (
  input  wire                        CLK_50M,
  input  wire                        rst_n,
  input  wire ipod_pkg::speed_keys_t keys_n,
  output ipod_pkg::speed_keys_t      events
);

  // Two flops against metastability, one more to see the edge
  ipod_pkg::speed_keys_t meta_n;
  ipod_pkg::speed_keys_t sync_n;
  ipod_pkg::speed_keys_t last_n;

  always_ff @(posedge CLK_50M)
  begin
    if (!rst_n)
    begin
      // Keys idle high
      meta_n <= '1;
      sync_n <= '1;
      last_n <= '1;
    end
    else
    begin
      meta_n <= keys_n;
      sync_n <= meta_n;
      last_n <= sync_n;
    end
  end

  // Press is a high to low step on the synced level
  // so a held key only fires once
  assign events = ipod_pkg::speed_keys_t'(last_n & ~sync_n);

endmodule

`default_nettype wire

// File: source/flash_pkg.sv
`default_nettype none

package flash_pkg;

  // ==============================
  // Flash memory bus
  // ==============================

  localparam int addr_w = 23;

  typedef logic [addr_w-1:0] word_addr_t;
  typedef logic [31:0]       word_t;

  // Last word of the sample area
  localparam word_addr_t last_word_addr = 23'h7FFFF;

  // Master side of the bus
  typedef struct packed {
    logic       read;
    word_addr_t address;
  } flash_req_t;

  // Slave side of the bus
  typedef struct packed {
    logic  waitrequest;
    logic  readdatavalid;
    word_t readdata;
  } flash_rsp_t;

endpackage

`default_nettype wire

// File: source/ipod_pkg.sv
`default_nettype none

package ipod_pkg;

  // ==============================
  // Sample rate
  // ==============================

  typedef logic [15:0] divisor_t;
  typedef logic [15:0] sample_t;

  // 50 MHz / 2267 gives roughly 22 kHz
  localparam divisor_t default_divisor = 16'd2267;
  localparam divisor_t speed_step      = 16'd100;
  localparam divisor_t min_divisor     = 16'd1267;
  localparam divisor_t max_divisor     = 16'd3267;

  // ==============================
  // Keyboard commands
  // ==============================

  typedef logic [7:0] ascii_t;

  localparam ascii_t cmd_play     = 8'h45;  // E
  localparam ascii_t cmd_pause    = 8'h44;  // D
  localparam ascii_t cmd_forward  = 8'h46;  // F
  localparam ascii_t cmd_backward = 8'h42;  // B
  localparam ascii_t cmd_restart  = 8'h52;  // R

  // Raw key levels or one-cycle key events
  typedef struct packed {
    logic up;
    logic down;
    logic reset;
  } speed_keys_t;

  // Restart is a pulse, the rest are levels
  typedef struct packed {
    logic playing;
    logic forward;
    logic restart;
  } play_ctrl_t;

endpackage

`default_nettype wire
